//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = dct_calc_tb
FILE_LIST = dct_calc.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dct_calc.f
+incdir+test
design/dct_pkg.sv
design/dct_sequencer.sv
design/dct_step_counter.sv
design/dct_butterfly.sv
design/dct_coef_rom.sv
design/dct_mac_bank.sv
design/dct_output_stage.sv
design/dct_calc.sv
test/dct_calc_tb.sv

//--- design/dct_butterfly.sv
`default_nettype none

module dct_butterfly (
   input  wire logic              clock,
   input  wire logic              reset_n,
   input  wire logic              forward,
   input  wire logic              sample_valid,
   input  wire logic [2:0]        sample_index,
   input  wire dct_pkg::sample_t  sample,
   output dct_pkg::operand_pair_t operands,
   output logic                   pair_loaded
);

   dct_pkg::sample_t held;
   logic             odd_strobe;

   assign odd_strobe = sample_valid & sample_index[0];

   // ------------------------------------------------------------
   // operand loading
   // ------------------------------------------------------------
   always_ff @(posedge clock) begin
      // even index, first half of the pair
      if (sample_valid && !sample_index[0]) begin
         held <= sample;
      end
      if (odd_strobe) begin
         if (forward) begin
            // sum feeds even outputs, difference feeds odd
            operands.op_even <= held + sample;
            operands.op_odd  <= held - sample;
         end else begin
            // inverse takes X(2p) and X(2p+1) as they come
            operands.op_even <= held;
            operands.op_odd  <= sample;
         end
      end
   end

   always_ff @(posedge clock or negedge reset_n) begin
      if (!reset_n) begin
         pair_loaded <= 1'b0;
      end else begin
         pair_loaded <= odd_strobe;
      end
   end

endmodule

`default_nettype wire

//--- design/dct_calc.sv
`default_nettype none

module dct_calc (
   input  wire logic             clock,
   input  wire logic             reset_n,
   input  wire logic             forward,
   input  wire logic             sample_valid,
   input  wire logic [2:0]       sample_index,
   input  wire dct_pkg::sample_t sample,
   output dct_pkg::sample_t      result,
   output logic                  result_valid,
   output logic [2:0]            result_index
);

   dct_pkg::operand_pair_t                   operands;
   logic                                     pair_loaded;
   logic                                     run;
   logic                                     drain;
   logic                                     steps_done;
   logic                                     slots_done;
   dct_pkg::mac_ctrl_t                       mac_ctrl;
   dct_pkg::slot_ctrl_t                      slot_ctrl;
   logic signed [dct_pkg::coef_width-1:0]    coef_even;
   logic signed [dct_pkg::coef_width-1:0]    coef_odd;
   logic [dct_pkg::block_size-1:0][dct_pkg::accum_width-1:0] lane_sums;

   // ------------------------------------------------------------
   // input side
   // ------------------------------------------------------------
   dct_butterfly dct_butterfly_i (
      .clock        (clock),
      .reset_n      (reset_n),
      .forward      (forward),
      .sample_valid (sample_valid),
      .sample_index (sample_index),
      .sample       (sample),
      .operands     (operands),
      .pair_loaded  (pair_loaded)
   );

   // control
   dct_sequencer dct_sequencer_i (
      .clock       (clock),
      .reset_n     (reset_n),
      .pair_loaded (pair_loaded),
      .steps_done  (steps_done),
      .slots_done  (slots_done),
      .run         (run),
      .drain       (drain)
   );

   dct_step_counter dct_step_counter_i (
      .clock      (clock),
      .reset_n    (reset_n),
      .run        (run),
      .drain      (drain),
      .mac_ctrl   (mac_ctrl),
      .slot_ctrl  (slot_ctrl),
      .steps_done (steps_done),
      .slots_done (slots_done)
   );

   // ------------------------------------------------------------
   // data path
   // ------------------------------------------------------------
   dct_coef_rom dct_coef_rom_i (
      .forward   (forward),
      .mac_ctrl  (mac_ctrl),
      .coef_even (coef_even),
      .coef_odd  (coef_odd)
   );

   dct_mac_bank dct_mac_bank_i (
      .clock     (clock),
      .reset_n   (reset_n),
      .operands  (operands),
      .coef_even (coef_even),
      .coef_odd  (coef_odd),
      .mac_ctrl  (mac_ctrl),
      .lane_sums (lane_sums)
   );

   dct_output_stage dct_output_stage_i (
      .clock        (clock),
      .reset_n      (reset_n),
      .forward      (forward),
      .lane_sums    (lane_sums),
      .slot_ctrl    (slot_ctrl),
      .result       (result),
      .result_valid (result_valid),
      .result_index (result_index)
   );

endmodule

`default_nettype wire

//--- design/dct_coef_rom.sv
`default_nettype none

module dct_coef_rom (
   input  wire logic                                 forward,
   input  wire dct_pkg::mac_ctrl_t                   mac_ctrl,
   output logic signed [dct_pkg::coef_width-1:0]     coef_even,
   output logic signed [dct_pkg::coef_width-1:0]     coef_odd
);

   logic [$clog2(dct_pkg::pair_count)-1:0] lane;
   logic [$clog2(dct_pkg::pair_count)-1:0] pair;
   logic [$clog2(dct_pkg::step_count)-1:0] addr_even;
   logic [$clog2(dct_pkg::step_count)-1:0] addr_odd;

   // step word read as its two fields
   assign lane = mac_ctrl.step.fields.lane;
   assign pair = mac_ctrl.step.fields.pair;

   // ------------------------------------------------------------
   // table addressing
   // ------------------------------------------------------------
   // forward reads row k = lane, inverse reads the transpose
   always_comb begin
      if (forward) begin
         addr_even = {lane, pair};
      end else begin
         addr_even = {pair, lane};
      end
   end

   // odd table is symmetric
   assign addr_odd = {lane, pair};

   // lookups
   assign coef_even = dct_pkg::even_coef[addr_even];
   assign coef_odd  = dct_pkg::odd_coef[addr_odd];

endmodule

`default_nettype wire

//--- design/dct_mac_bank.sv
`default_nettype none

module dct_mac_bank (
   input  wire logic                                      clock,
   input  wire logic                                      reset_n,
   input  wire dct_pkg::operand_pair_t                    operands,
   input  wire logic signed [dct_pkg::coef_width-1:0]     coef_even,
   input  wire logic signed [dct_pkg::coef_width-1:0]     coef_odd,
   input  wire dct_pkg::mac_ctrl_t                        mac_ctrl,
   output logic [dct_pkg::block_size-1:0][dct_pkg::accum_width-1:0] lane_sums
);

   logic signed [dct_pkg::product_width-1:0] prod_even;
   logic signed [dct_pkg::product_width-1:0] prod_odd;
   // step of the products now in the registers
   dct_pkg::step_word_t                      prod_step;
   logic                                     first_pair;

   // ------------------------------------------------------------
   // registered multipliers
   // ------------------------------------------------------------
   always_ff @(posedge clock) begin
      if (mac_ctrl.active) begin
         prod_even <= dct_pkg::product_width'(operands.op_even)
                      * dct_pkg::product_width'(coef_even);
         prod_odd  <= dct_pkg::product_width'(operands.op_odd)
                      * dct_pkg::product_width'(coef_odd);
      end
   end

   always_ff @(posedge clock or negedge reset_n) begin
      if (!reset_n) begin
         prod_step.raw <= '0;
      end else if (mac_ctrl.active) begin
         prod_step <= mac_ctrl.step;
      end
   end

   // pair 0 starts a fresh sum
   assign first_pair = (prod_step.fields.pair == '0);

   // ------------------------------------------------------------
   // lane accumulators
   // ------------------------------------------------------------
   // even result of lane L in entry 2L, odd in 2L+1
   always_ff @(posedge clock) begin
      if (mac_ctrl.product_valid) begin
         if (first_pair) begin
            lane_sums[{prod_step.fields.lane, 1'b0}] <= dct_pkg::accum_width'(prod_even);
            lane_sums[{prod_step.fields.lane, 1'b1}] <= dct_pkg::accum_width'(prod_odd);
         end else begin
            lane_sums[{prod_step.fields.lane, 1'b0}] <=
               lane_sums[{prod_step.fields.lane, 1'b0}] + dct_pkg::accum_width'(prod_even);
            lane_sums[{prod_step.fields.lane, 1'b1}] <=
               lane_sums[{prod_step.fields.lane, 1'b1}] + dct_pkg::accum_width'(prod_odd);
         end
      end
   end

endmodule

`default_nettype wire

//--- design/dct_output_stage.sv
`default_nettype none

module dct_output_stage (
   input  wire logic                    clock,
   input  wire logic                    reset_n,
   input  wire logic                    forward,
   input  wire logic [dct_pkg::block_size-1:0][dct_pkg::accum_width-1:0] lane_sums,
   input  wire dct_pkg::slot_ctrl_t     slot_ctrl,
   output dct_pkg::sample_t             result,
   output logic                         result_valid,
   output logic [2:0]                   result_index
);

   dct_pkg::sample_t    cap_even;
   dct_pkg::sample_t    cap_odd;
   dct_pkg::slot_ctrl_t slot_d;
   dct_pkg::sample_t    next_result;
   logic [2:0]          next_index;

   // ------------------------------------------------------------
   // capture, one lane per even slot, scaled by 2^-9
   // ------------------------------------------------------------
   always_ff @(posedge clock) begin
      if (slot_ctrl.active && !slot_ctrl.slot[0]) begin
         cap_even <= lane_sums[{slot_ctrl.slot[2:1], 1'b0}][dct_pkg::frac_bits +: dct_pkg::data_width];
         cap_odd  <= lane_sums[{slot_ctrl.slot[2:1], 1'b1}][dct_pkg::frac_bits +: dct_pkg::data_width];
      end
   end

   always_ff @(posedge clock or negedge reset_n) begin
      if (!reset_n) begin
         slot_d <= '0;
      end else begin
         slot_d <= slot_ctrl;
      end
   end

   // recombination and index map
   always_comb begin
      if (forward) begin
         next_result = slot_d.slot[0] ? cap_odd : cap_even;
         next_index  = slot_d.slot;
      end else if (!slot_d.slot[0]) begin
         // y(k), wraps at 13 bits
         next_result = cap_even + cap_odd;
         next_index  = {1'b0, slot_d.slot[2:1]};
      end else begin
         // y(7-k)
         next_result = cap_even - cap_odd;
         next_index  = {1'b1, ~slot_d.slot[2:1]};
      end
   end

   // ------------------------------------------------------------
   // output registers
   // ------------------------------------------------------------
   always_ff @(posedge clock or negedge reset_n) begin
      if (!reset_n) begin
         result       <= '0;
         result_valid <= 1'b0;
         result_index <= '0;
      end else begin
         result_valid <= slot_d.active;
         if (slot_d.active) begin
            result       <= next_result;
            result_index <= next_index;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/dct_pkg.sv
`default_nettype none

package dct_pkg;

   // ------------------------------------------------------------
   // widths
   // ------------------------------------------------------------
   localparam int data_width    = 13;
   localparam int coef_width    = 9;
   localparam int product_width = data_width + coef_width - 1;
   // room for four products per lane
   localparam int accum_width   = product_width + 2;
   localparam int frac_bits     = 9;

   // schedule
   localparam int block_size = 8;
   localparam int pair_count = 4;
   localparam int step_count = 16;
   localparam int last_step  = 15;
   localparam int last_slot  = 7;

   // sequencer state encodings
   localparam logic [1:0] seq_idle     = 2'd0;
   localparam logic [1:0] seq_multiply = 2'd1;
   localparam logic [1:0] seq_drain    = 2'd2;

   // ------------------------------------------------------------
   // coefficient tables, address {lane, pair}, scaled by 256
   // ------------------------------------------------------------
   localparam logic signed [coef_width-1:0] even_coef [step_count] = '{
      9'h0B5, 9'h0B5, 9'h0B5, 9'h0B5,
      9'h0ED, 9'h062, 9'h19E, 9'h113,
      9'h0B5, 9'h14B, 9'h14B, 9'h0B5,
      9'h062, 9'h113, 9'h0ED, 9'h19E
   };

   // symmetric, same address in both directions
   localparam logic signed [coef_width-1:0] odd_coef [step_count] = '{
      9'h0FB, 9'h0D5, 9'h08E, 9'h032,
      9'h0D5, 9'h1CE, 9'h105, 9'h172,
      9'h08E, 9'h105, 9'h032, 9'h0D5,
      9'h032, 9'h172, 9'h0D5, 9'h105
   };

   // ------------------------------------------------------------
   // shared types
   // ------------------------------------------------------------
   typedef logic signed [data_width-1:0] sample_t;

   typedef struct packed {
      sample_t op_even;
      sample_t op_odd;
   } operand_pair_t;

   // one step count, seen as a number or as pair and lane
   typedef union packed {
      logic [$clog2(step_count)-1:0] raw;
      struct packed {
         logic [$clog2(pair_count)-1:0] pair;
         logic [$clog2(pair_count)-1:0] lane;
      } fields;
   } step_word_t;

   typedef struct packed {
      logic       active;
      logic       product_valid;
      step_word_t step;
   } mac_ctrl_t;

   typedef struct packed {
      logic                          active;
      logic [$clog2(block_size)-1:0] slot;
   } slot_ctrl_t;

endpackage

`default_nettype wire

//--- design/dct_sequencer.sv
`default_nettype none

module dct_sequencer (
   input  wire logic clock,
   input  wire logic reset_n,
   input  wire logic pair_loaded,
   input  wire logic steps_done,
   input  wire logic slots_done,
   output logic      run,
   output logic      drain
);

   logic [1:0]                             state;
   // steps still owed to the current pair
   logic [$clog2(dct_pkg::pair_count)-1:0] burst_left;

   // ------------------------------------------------------------
   // block state machine
   // ------------------------------------------------------------
   always_ff @(posedge clock or negedge reset_n) begin
      if (!reset_n) begin
         state <= dct_pkg::seq_idle;
      end else begin
         case (state)
            dct_pkg::seq_idle: begin
               if (pair_loaded) begin
                  state <= dct_pkg::seq_multiply;
               end
            end
            // steps_done marks the last product going into its lane
            dct_pkg::seq_multiply: begin
               if (steps_done) begin
                  state <= dct_pkg::seq_drain;
               end
            end
            dct_pkg::seq_drain: begin
               if (slots_done) begin
                  state <= dct_pkg::seq_idle;
               end
            end
            default: begin
               state <= dct_pkg::seq_idle;
            end
         endcase
      end
   end

   // four steps per pair, starting on the pair_loaded cycle
   always_ff @(posedge clock or negedge reset_n) begin
      if (!reset_n) begin
         burst_left <= '0;
      end else if (pair_loaded) begin
         burst_left <= '1;
      end else if (burst_left != '0) begin
         burst_left <= burst_left - 1'b1;
      end
   end

   // a gap between pairs leaves run low and the step count held
   assign run   = pair_loaded | (burst_left != '0);
   assign drain = (state == dct_pkg::seq_drain);

endmodule

`default_nettype wire

//--- design/dct_step_counter.sv
`default_nettype none

module dct_step_counter (
   input  wire logic           clock,
   input  wire logic           reset_n,
   input  wire logic           run,
   input  wire logic           drain,
   output dct_pkg::mac_ctrl_t  mac_ctrl,
   output dct_pkg::slot_ctrl_t slot_ctrl,
   output logic                steps_done,
   output logic                slots_done
);

   dct_pkg::step_word_t                    step_q;
   logic                                   product_valid_q;
   logic [$clog2(dct_pkg::block_size)-1:0] slot_q;

   // ------------------------------------------------------------
   // multiply steps
   // ------------------------------------------------------------
   always_ff @(posedge clock or negedge reset_n) begin
      if (!reset_n) begin
         step_q.raw      <= '0;
         product_valid_q <= 1'b0;
         steps_done      <= 1'b0;
      end else begin
         // wraps back to 0 after step 15
         if (run) begin
            step_q.raw <= step_q.raw + 1'b1;
         end
         product_valid_q <= run;
         // high while the last product is accumulated
         steps_done <= run & (step_q.raw == $bits(step_q.raw)'(dct_pkg::last_step));
      end
   end

   assign mac_ctrl.active        = run;
   assign mac_ctrl.product_valid = product_valid_q;
   assign mac_ctrl.step          = step_q;

   // drain slots
   always_ff @(posedge clock or negedge reset_n) begin
      if (!reset_n) begin
         slot_q <= '0;
      end else if (drain) begin
         slot_q <= slot_q + 1'b1;
      end else begin
         slot_q <= '0;
      end
   end

   assign slot_ctrl.active = drain;
   assign slot_ctrl.slot   = slot_q;
   assign slots_done       = drain & (slot_q == $bits(slot_q)'(dct_pkg::last_slot));

endmodule

`default_nettype wire

//--- test/dct_model.svh
`ifndef DCT_MODEL_SVH
`define DCT_MODEL_SVH

// ------------------------------------------------------------
// random numbers
// ------------------------------------------------------------
// 32-bit xorshift, shifts 13 17 5
function automatic logic [31:0] xorshift32(input logic [31:0] state);
   logic [31:0] x;
   x = state;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

// ------------------------------------------------------------
// reference arithmetic
// ------------------------------------------------------------
// low 13 bits, sign extended
function automatic int wrap_sample(input int value);
   logic signed [12:0] low;
   low = 13'(value);
   return int'(low);
endfunction

// table weight at row, column
function automatic int weight(input logic even_table, input int row, input int col);
   logic [3:0] addr;
   addr = 4'(row * 4 + col);
   if (even_table) begin
      return int'(dct_pkg::even_coef[addr]);
   end else begin
      return int'(dct_pkg::odd_coef[addr]);
   end
endfunction

// forward uses pair sums, inverse the transposed table on a_p
function automatic int even_part(input logic fwd, input int k);
   int acc;
   acc = 0;
   for (int p = 0; p < 4; p++) begin
      if (fwd) begin
         acc = acc + weight(1'b1, k, p) * (pair_a[p] + pair_b[p]);
      end else begin
         acc = acc + weight(1'b1, p, k) * pair_a[p];
      end
   end
   return wrap_sample(acc >>> 9);
endfunction

// odd table is the same in both directions
function automatic int odd_part(input logic fwd, input int k);
   int acc;
   acc = 0;
   for (int p = 0; p < 4; p++) begin
      if (fwd) begin
         acc = acc + weight(1'b0, k, p) * (pair_a[p] - pair_b[p]);
      end else begin
         acc = acc + weight(1'b0, k, p) * pair_b[p];
      end
   end
   return wrap_sample(acc >>> 9);
endfunction

// expected results in output order
task automatic build_expected(input logic fwd);
   int e;
   int o;
   for (int k = 0; k < 4; k++) begin
      e = even_part(fwd, k);
      o = odd_part(fwd, k);
      if (fwd) begin
         expected_value[2 * k]     = e;
         expected_index[2 * k]     = 3'(2 * k);
         expected_value[2 * k + 1] = o;
         expected_index[2 * k + 1] = 3'(2 * k + 1);
      end else begin
         // y(k) first, then y(7-k)
         expected_value[2 * k]     = wrap_sample(e + o);
         expected_index[2 * k]     = 3'(k);
         expected_value[2 * k + 1] = wrap_sample(e - o);
         expected_index[2 * k + 1] = 3'(7 - k);
      end
   end
endtask

`endif

//--- test/dct_calc_tb.sv
`default_nettype none

module dct_calc_tb;

   timeunit 1ns;
   timeprecision 1ps;

   logic             clock;
   logic             reset_n;
   logic             forward;
   logic             sample_valid;
   logic [2:0]       sample_index;
   dct_pkg::sample_t sample;
   dct_pkg::sample_t result;
   logic             result_valid;
   logic [2:0]       result_index;

   // block under test, a_p on even index and b_p on odd
   int          pair_a [4];
   int          pair_b [4];
   int          expected_value [8];
   logic [2:0]  expected_index [8];
   logic [31:0] rng_state;

   // results seen in the current block
   logic [3:0] out_count;
   logic       armed;
   logic [4:0] edges_after_last;

   int   error_count;
   int   tests_run;
   int   tests_passed;
   int   errors_before;
   logic timed_out;

   `include "dct_model.svh"

   dct_calc dct_calc_i (
      .clock        (clock),
      .reset_n      (reset_n),
      .forward      (forward),
      .sample_valid (sample_valid),
      .sample_index (sample_index),
      .sample       (sample),
      .result       (result),
      .result_valid (result_valid),
      .result_index (result_index)
   );

   initial begin
      clock = 1'b0;
      forever begin
         #10 clock = ~clock;
      end
   end

   // ------------------------------------------------------------
   // result tracking and checks
   // ------------------------------------------------------------
   always @(posedge clock or negedge reset_n) begin
      if (!reset_n) begin
         out_count        <= '0;
         armed            <= 1'b0;
         edges_after_last <= '0;
      end else begin
         // index 0 opens a new block
         if (sample_valid && sample_index == 3'd0) begin
            out_count <= '0;
         end else if (result_valid) begin
            out_count <= out_count + 4'd1;
         end
         if (sample_valid && sample_index == 3'd7) begin
            armed            <= 1'b1;
            edges_after_last <= '0;
         end else if (edges_after_last != 5'd31) begin
            edges_after_last <= edges_after_last + 5'd1;
         end
      end
   end

   // eight valids, the first one 7 edges after index 7
   valid_window: assert property (@(posedge clock) disable iff (!reset_n)
      result_valid == (armed && edges_after_last >= 5'd7 && edges_after_last <= 5'd14))
      else begin
         error_count = error_count + 1;
         $display("ERROR %0t: result_valid %0b at %0d edges after index 7", $time,
                  $sampled(result_valid), $sampled(edges_after_last));
      end

   result_match: assert property (@(posedge clock) disable iff (!reset_n)
      result_valid |-> (!out_count[3]
                        && int'(result) == expected_value[out_count[2:0]]
                        && result_index == expected_index[out_count[2:0]]))
      else begin
         error_count = error_count + 1;
         $display("ERROR %0t: result %0d index %0d wrong at output %0d", $time,
                  $sampled(result), $sampled(result_index), $sampled(out_count));
      end

   // ------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------
   task automatic next_cycle();
      @(posedge clock);
      #2;
   endtask

   task automatic drive_sample(input logic [2:0] index, input int value);
      sample_valid = 1'b1;
      sample_index = index;
      sample       = 13'(value);
      next_cycle();
   endtask

   // samples within +-255
   task automatic fill_random_block();
      for (int p = 0; p < 4; p++) begin
         rng_state = xorshift32(rng_state);
         pair_a[p] = int'(rng_state % 32'd511) - 255;
         rng_state = xorshift32(rng_state);
         pair_b[p] = int'(rng_state % 32'd511) - 255;
      end
   endtask

   // gap adds idle cycles between pairs, more for later pairs
   task automatic send_block(input logic fwd, input int gap, input string what);
      int waited;
      if (!timed_out) begin
         build_expected(fwd);
         forward = fwd;
         for (int p = 0; p < 4; p++) begin
            drive_sample(3'(2 * p), pair_a[p]);
            drive_sample(3'(2 * p + 1), pair_b[p]);
            sample_valid = 1'b0;
            // four cycles per pair at full speed
            if (p < 3) begin
               repeat (2 + gap * (p + 1)) next_cycle();
            end
         end
         waited = 0;
         while (out_count < 4'd8 && waited < 40) begin
            next_cycle();
            waited = waited + 1;
         end
         if (out_count < 4'd8) begin
            $display("timeout: %s gave only %0d of 8 results", what, out_count);
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic report_test(input string name, input int errors_at_start);
      tests_run = tests_run + 1;
      if (!timed_out && error_count == errors_at_start) begin
         tests_passed = tests_passed + 1;
         $display("test %0d, %s: passed", tests_run, name);
      end else begin
         $display("test %0d, %s: failed", tests_run, name);
      end
   endtask

   initial begin
      reset_n      = 1'b0;
      forward      = 1'b1;
      sample_valid = 1'b0;
      sample_index = '0;
      sample       = '0;
      rng_state    = 32'd4653;
      error_count  = 0;
      tests_run    = 0;
      tests_passed = 0;
      timed_out    = 1'b0;
      repeat (5) next_cycle();
      reset_n = 1'b1;

      // quiet output before any block
      errors_before = error_count;
      repeat (12) next_cycle();
      report_test("idle after reset", errors_before);

      errors_before = error_count;
      fill_random_block();
      send_block(1'b1, 0, "forward block");
      report_test("forward random block", errors_before);

      errors_before = error_count;
      fill_random_block();
      send_block(1'b0, 0, "inverse block");
      report_test("inverse random block", errors_before);

      // full-scale values, latency in both directions
      errors_before = error_count;
      pair_a = '{255, -255, 255, -255};
      pair_b = '{255, 255, -255, -255};
      send_block(1'b1, 0, "forward full-scale block");
      send_block(1'b0, 0, "inverse full-scale block");
      report_test("latency both directions", errors_before);

      // one block, without and with gaps
      errors_before = error_count;
      fill_random_block();
      send_block(1'b1, 0, "forward block");
      send_block(1'b1, 3, "forward gapped block");
      send_block(1'b0, 0, "inverse block");
      send_block(1'b0, 2, "inverse gapped block");
      report_test("gaps between pairs", errors_before);

      errors_before = error_count;
      for (int b = 0; b < 4; b++) begin
         fill_random_block();
         send_block(b % 2 == 0, 0, "alternating block");
      end
      report_test("alternating directions", errors_before);

      $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run, tests_passed,
               tests_run - tests_passed, error_count);
      if (timed_out || error_count != 0 || tests_passed != tests_run) begin
         $display("RESULT: FAIL");
      end else begin
         $display("RESULT: PASS");
      end
      $finish;
   end

endmodule

`default_nettype wire
